//--- basicOpLane.sv
module basicOpLane
#(
	parameter int ADDR_W = 8
)
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input basicOpPkg::basicOpCode opCode,
	input basicOpPkg::basicOpWord a,
	input basicOpPkg::basicOpWord b,
	input basicOpPkg::basicOpWord c,
	input logic [ADDR_W-1:0] dest,
	output logic outValid,
	input logic outReady,
	output basicOpPkg::basicOpWord result,
	output logic overflow,
	output logic [ADDR_W-1:0] resDest
);

	import basicOpPkg::*;

	//////////////////////////////////////////////////
	// Saturation helpers
	//////////////////////////////////////////////////

	function automatic logic fits16(input logic signed [63:0] v);
		return (v <= 64'(MAX16)) && (v >= 64'(MIN16));
	endfunction

	function automatic logic signed [15:0] sat16(input logic signed [63:0] v);
		if (v > 64'(MAX16))
			return MAX16;
		else if (v < 64'(MIN16))
			return MIN16;
		return v[15:0];
	endfunction

	function automatic logic fits32(input logic signed [63:0] v);
		return (v <= 64'(MAX32)) && (v >= 64'(MIN32));
	endfunction

	function automatic logic signed [31:0] sat32(input logic signed [63:0] v);
		if (v > 64'(MAX32))
			return MAX32;
		else if (v < 64'(MIN32))
			return MIN32;
		return v[31:0];
	endfunction

	// 16-bit result into lo, sign into hi
	function automatic basicOpWord toWord(input logic signed [15:0] v);
		basicOpWord r;
		r.w.lo = v;
		r.w.hi = {16{v[15]}};
		return r;
	endfunction

	// Leading sign bits, zero input gives zero
	function automatic logic signed [15:0] normS(input logic signed [15:0] v);
		logic [15:0] x;
		logic [15:0] n;
		logic found;
		x = v[15] ? ~v : v;
		n = '0;
		found = 1'b0;
		if (v == 16'sd0)
			return '0;
		for (int i = 14; i >= 0; i--)
		begin
			if (x[i])
				found = 1'b1;
			else if (!found)
				n = n + 16'd1;
		end
		return n;
	endfunction

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////

	logic signed [63:0] sum16;
	logic signed [63:0] diff16;
	logic signed [63:0] prod;
	logic signed [63:0] prodQ15;
	logic lMultOvf;
	logic signed [31:0] lMult;
	logic signed [63:0] sumL;
	logic signed [63:0] diffL;
	logic signed [63:0] macL;
	logic signed [63:0] msuL;
	logic signed [15:0] cnt;
	logic signed [16:0] negCnt;
	logic signed [16:0] lsh32;
	logic [16:0] right32;
	logic [5:0] left16;
	logic [5:0] left32;
	logic signed [63:0] wide16;
	logic signed [63:0] wide32;
	basicOpWord resNext;
	logic ovfNext;

	assign sum16 = 64'(a.w.lo) + 64'(b.w.lo);
	assign diff16 = 64'(a.w.lo) - 64'(b.w.lo);
	assign prod = 64'(a.w.lo) * 64'(b.w.lo);
	assign prodQ15 = prod >>> 15;

	// Doubled product, only MIN16 * MIN16 saturates
	assign lMultOvf = (prod == 64'sh4000_0000);
	assign lMult = lMultOvf ? MAX32 : {prod[30:0], 1'b0};

	assign sumL = 64'(a.l) + 64'(b.l);
	assign diffL = 64'(a.l) - 64'(b.l);
	assign macL = 64'(c.l) + 64'(lMult);
	assign msuL = 64'(c.l) - 64'(lMult);

	// Shift counts, positive lsh means a left shift
	assign cnt = b.w.lo;
	assign negCnt = -(17'(cnt));
	assign lsh32 = (opCode == opLShl) ? 17'(cnt) : negCnt;
	assign right32 = -lsh32;
	assign left16 = (negCnt > 17'sd16) ? 6'd16 : negCnt[5:0];
	assign left32 = (lsh32 > 17'sd32) ? 6'd32 : lsh32[5:0];
	assign wide16 = 64'(a.w.lo) <<< left16;
	assign wide32 = 64'(a.l) <<< left32;

	always_comb
	begin
		resNext = '0;
		ovfNext = 1'b0;
		case (opCode)
			opAdd:
			begin
				resNext = toWord(sat16(sum16));
				ovfNext = !fits16(sum16);
			end
			opSub:
			begin
				resNext = toWord(sat16(diff16));
				ovfNext = !fits16(diff16);
			end
			opMult:
			begin
				resNext = toWord(sat16(prodQ15));
				ovfNext = !fits16(prodQ15);
			end
			opShr:
			begin
				// Negative count turns into a saturating shl
				if (negCnt > 17'sd0)
				begin
					resNext = toWord(sat16(wide16));
					ovfNext = !fits16(wide16);
				end
				else if (cnt >= 16'sd15)
					resNext = toWord({16{a.w.lo[15]}});
				else
					resNext = toWord(a.w.lo >>> cnt[3:0]);
			end
			opLAdd:
			begin
				resNext.l = sat32(sumL);
				ovfNext = !fits32(sumL);
			end
			opLSub:
			begin
				resNext.l = sat32(diffL);
				ovfNext = !fits32(diffL);
			end
			opLMult:
			begin
				resNext.l = lMult;
				ovfNext = lMultOvf;
			end
			opLMac:
			begin
				resNext.l = sat32(macL);
				ovfNext = lMultOvf || !fits32(macL);
			end
			opLMsu:
			begin
				resNext.l = sat32(msuL);
				ovfNext = lMultOvf || !fits32(msuL);
			end
			opLShl, opLShr:
			begin
				if (lsh32 > 17'sd0)
				begin
					resNext.l = sat32(wide32);
					ovfNext = !fits32(wide32);
				end
				else if (right32 >= 17'd31)
					resNext.l = {32{a.l[31]}};
				else
					resNext.l = a.l >>> right32[4:0];
			end
			opNormS:
				resNext = toWord(normS(a.w.lo));
			default:
				resNext = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	// Free, or emptied in this same cycle
	assign inReady = !outValid || outReady;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else if (inValid && inReady)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
		begin
			result <= resNext;
			overflow <= ovfNext;
			resDest <= dest;
		end
	end

endmodule

//--- basicOpMonitor.sv
module basicOpMonitor
#(
	parameter int ADDR_W = 8
)
(
	input logic clk,
	input logic rstN,
	input logic opValid,
	input logic opReady,
	input basicOpPkg::basicOpCode opCode,
	input logic [31:0] opA,
	input logic [31:0] opB,
	input logic [31:0] opC,
	input logic [ADDR_W-1:0] opDest,
	input logic resValid,
	input logic resReady,
	input logic [31:0] resData,
	input logic resOverflow,
	input logic [ADDR_W-1:0] resDest,
	input logic memSel,
	input logic testWrite,
	input logic [ADDR_W-1:0] testAddr,
	input logic [31:0] testData,
	input logic [ADDR_W-1:0] readAddr,
	input logic [31:0] readData,
	input logic checkRead,
	output int errorCount,
	output int checkCount,
	output int pending
);

	import basicOpPkg::*;

	localparam int ENTRY_W = 33 + ADDR_W;

	logic [ENTRY_W-1:0] expQ [$];
	logic [31:0] shadow [2**ADDR_W];
	logic [31:0] readExp;
	logic readPending;

	//////////////////////////////////////////////////
	// Reference model of the operators
	//////////////////////////////////////////////////

	function automatic longint limitHi(input int bits);
		return (longint'(1) <<< (bits - 1)) - 1;
	endfunction

	function automatic logic outOfRange(input longint v, input int bits);
		return (v > limitHi(bits)) || (v < -limitHi(bits) - 1);
	endfunction

	function automatic longint clampTo(input longint v, input int bits);
		if (v > limitHi(bits))
			return limitHi(bits);
		if (v < -limitHi(bits) - 1)
			return -limitHi(bits) - 1;
		return v;
	endfunction

	function automatic logic [31:0] signExt16(input longint v);
		return {{16{v[15]}}, v[15:0]};
	endfunction

	function automatic logic [32:0] modelOp(input basicOpCode code, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] c);
		longint x;
		longint y;
		longint la;
		longint s;
		longint lm;
		longint n;
		logic lmOvf;
		logic [31:0] r;
		logic o;
		x = longint'($signed(a[15:0]));
		y = longint'($signed(b[15:0]));
		la = longint'($signed(a));
		r = '0;
		o = 1'b0;
		lmOvf = (x == -32768) && (y == -32768);
		lm = lmOvf ? limitHi(32) : 2 * x * y;
		case (code)
			opAdd, opSub, opMult:
			begin
				if (code == opAdd)
					s = x + y;
				else if (code == opSub)
					s = x - y;
				else
					s = (x * y) >>> 15;
				r = signExt16(clampTo(s, 16));
				o = outOfRange(s, 16);
			end
			opShr:
			begin
				if (y < 0)
				begin
					// Left shift, anything past 16 saturates the same
					n = (-y > 16) ? 16 : -y;
					s = x <<< n;
					r = signExt16(clampTo(s, 16));
					o = outOfRange(s, 16);
				end
				else if (y >= 15)
					r = (x < 0) ? 32'hffff_ffff : 32'h0;
				else
					r = signExt16(x >>> y);
			end
			opLAdd, opLSub:
			begin
				s = (code == opLAdd) ? la + longint'($signed(b)) : la - longint'($signed(b));
				r = 32'(clampTo(s, 32));
				o = outOfRange(s, 32);
			end
			opLMult:
			begin
				r = 32'(lm);
				o = lmOvf;
			end
			opLMac, opLMsu:
			begin
				s = (code == opLMac) ? longint'($signed(c)) + lm : longint'($signed(c)) - lm;
				r = 32'(clampTo(s, 32));
				o = lmOvf || outOfRange(s, 32);
			end
			opLShl, opLShr:
			begin
				n = (code == opLShl) ? y : -y;
				if (n > 0)
				begin
					s = la <<< ((n > 32) ? 32 : n);
					r = 32'(clampTo(s, 32));
					o = outOfRange(s, 32);
				end
				else if (-n >= 31)
					r = (la < 0) ? 32'hffff_ffff : 32'h0;
				else
					r = 32'(la >>> (-n));
			end
			opNormS:
			begin
				s = (x < 0) ? ~x : x;
				n = 0;
				if (x == 0)
					n = 0;
				else if (s == 0)
					n = 15;
				else
				begin
					while (s < 16384)
					begin
						s = s <<< 1;
						n++;
					end
				end
				r = n[31:0];
			end
			default:
				r = '0;
		endcase
		return {o, r};
	endfunction

	//////////////////////////////////////////////////
	// Compare at each rising edge
	//////////////////////////////////////////////////

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		pending = 0;
		readPending = 1'b0;
	end

	always @(posedge clk)
	begin
		logic [ENTRY_W-1:0] e;
		if (!rstN)
		begin
			expQ.delete();
			readPending = 1'b0;
		end
		else
		begin
			// Registered read reflects the previous edge
			if (readPending)
			begin
				checkCount++;
				if (readData !== readExp)
				begin
					$display("Error readData expected %h actual %h", readExp, readData);
					errorCount++;
				end
			end
			readExp = shadow[readAddr];
			readPending = checkRead;
			if (resValid && resReady)
			begin
				if (expQ.size() == 0)
				begin
					$display("A result came out with no operation outstanding");
					errorCount++;
				end
				else
				begin
					e = expQ.pop_front();
					checkCount++;
					if (resData !== e[31:0])
					begin
						$display("Error resData expected %h actual %h", e[31:0], resData);
						errorCount++;
					end
					if (resOverflow !== e[32])
					begin
						$display("Error resOverflow expected %h actual %h", e[32], resOverflow);
						errorCount++;
					end
					if (resDest !== e[ENTRY_W-1:33])
					begin
						$display("Error resDest expected %h actual %h", e[ENTRY_W-1:33], resDest);
						errorCount++;
					end
					if (!memSel)
						shadow[e[ENTRY_W-1:33]] = e[31:0];
				end
			end
			if (memSel && testWrite)
				shadow[testAddr] = testData;
			if (opValid && opReady)
				expQ.push_back({opDest, modelOp(opCode, opA, opB, opC)});
		end
		pending = expQ.size();
	end

endmodule

//--- basicOpPipe.f
basicOpPkg.sv
opDispatcher.sv
basicOpLane.sv
resultCollector.sv
scratchMem.sv
basicOpPipe.sv
tbClock.sv
basicOpMonitor.sv
basicOpPipe_checker.sv
basicOpPipe_tb.sv

//--- basicOpPipe.sv
module basicOpPipe
#(
	parameter int NUM_LANES = 4,
	parameter int ADDR_W = 8
)
(
	input logic clk,
	input logic rstN,
	input logic opValid,
	output logic opReady,
	input basicOpPkg::basicOpCode opCode,
	input basicOpPkg::basicOpWord opA,
	input basicOpPkg::basicOpWord opB,
	input basicOpPkg::basicOpWord opC,
	input logic [ADDR_W-1:0] opDest,
	output logic resValid,
	input logic resReady,
	output basicOpPkg::basicOpWord resData,
	output logic resOverflow,
	output logic [ADDR_W-1:0] resDest,
	input logic memSel,
	input logic testWrite,
	input logic [ADDR_W-1:0] testAddr,
	input logic [31:0] testData,
	input logic [ADDR_W-1:0] readAddr,
	output logic [31:0] readData
);

	import basicOpPkg::*;

	logic [NUM_LANES-1:0] laneInValid;
	logic [NUM_LANES-1:0] laneInReady;
	logic [NUM_LANES-1:0] laneOutValid;
	logic [NUM_LANES-1:0] laneOutReady;
	logic [NUM_LANES-1:0] laneOverflow;
	basicOpWord [NUM_LANES-1:0] laneResult;
	logic [NUM_LANES-1:0][ADDR_W-1:0] laneResDest;
	basicOpCode laneOpCode;
	basicOpWord laneA;
	basicOpWord laneB;
	basicOpWord laneC;
	logic [ADDR_W-1:0] laneDest;
	logic wrEn;
	logic [ADDR_W-1:0] wrAddr;
	logic [31:0] wrData;

	//////////////////////////////////////////////////
	// Issue side
	//////////////////////////////////////////////////

	opDispatcher #(.NUM_LANES(NUM_LANES), .ADDR_W(ADDR_W)) uDispatcher
	(
		.clk(clk),
		.rstN(rstN),
		.opValid(opValid),
		.opReady(opReady),
		.opCode(opCode),
		.opA(opA),
		.opB(opB),
		.opC(opC),
		.opDest(opDest),
		.laneInReady(laneInReady),
		.laneInValid(laneInValid),
		.laneOpCode(laneOpCode),
		.laneA(laneA),
		.laneB(laneB),
		.laneC(laneC),
		.laneDest(laneDest)
	);

	// One operator lane per slot
	for (genvar i = 0; i < NUM_LANES; i++)
	begin : genLane
		basicOpLane #(.ADDR_W(ADDR_W)) uLane
		(
			.clk(clk),
			.rstN(rstN),
			.inValid(laneInValid[i]),
			.inReady(laneInReady[i]),
			.opCode(laneOpCode),
			.a(laneA),
			.b(laneB),
			.c(laneC),
			.dest(laneDest),
			.outValid(laneOutValid[i]),
			.outReady(laneOutReady[i]),
			.result(laneResult[i]),
			.overflow(laneOverflow[i]),
			.resDest(laneResDest[i])
		);
	end

	//////////////////////////////////////////////////
	// Drain side and memory
	//////////////////////////////////////////////////

	resultCollector #(.NUM_LANES(NUM_LANES), .ADDR_W(ADDR_W)) uCollector
	(
		.clk(clk),
		.rstN(rstN),
		.laneOutValid(laneOutValid),
		.laneOutReady(laneOutReady),
		.laneResult(laneResult),
		.laneOverflow(laneOverflow),
		.laneResDest(laneResDest),
		.resValid(resValid),
		.resReady(resReady),
		.resData(resData),
		.resOverflow(resOverflow),
		.resDest(resDest),
		.memSel(memSel),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	scratchMem #(.ADDR_W(ADDR_W)) uMem
	(
		.clk(clk),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.memSel(memSel),
		.testWrite(testWrite),
		.testAddr(testAddr),
		.testData(testData),
		.readAddr(readAddr),
		.readData(readData)
	);

endmodule

//--- basicOpPipe_checker.sv
module basicOpPipe_checker
#(
	parameter int ADDR_W = 8
)
(
	input logic clk,
	input logic rstN,
	input logic opValid,
	input logic opReady,
	input logic [3:0] opCode,
	input logic [31:0] opA,
	input logic [31:0] opB,
	input logic [31:0] opC,
	input logic [ADDR_W-1:0] opDest,
	input logic resValid,
	input logic resReady,
	input logic [31:0] resData,
	input logic resOverflow,
	input logic [ADDR_W-1:0] resDest,
	input logic memSel,
	input logic wrEn
);

	// Input stream holds until accepted
	opHold: assert property (@(posedge clk) disable iff (!rstN)
		opValid && !opReady |=> opValid && $stable({opCode, opA, opB, opC, opDest}))
		else $error("op stream changed before opReady");

	// Result stream holds until taken
	resHold: assert property (@(posedge clk) disable iff (!rstN)
		resValid && !resReady |=> resValid && $stable({resData, resOverflow, resDest}))
		else $error("result stream changed before resReady");

	// Test port owns the memory
	noCollectorWrite: assert property (@(posedge clk) disable iff (!rstN) !(wrEn && memSel))
		else $error("collector wrote while memSel high");

	knownOutputs: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown({opReady, resValid, wrEn})
		&& (!resValid || !$isunknown({resData, resOverflow, resDest})))
		else $error("unknown value on a DUT output");

endmodule

bind basicOpPipe basicOpPipe_checker #(.ADDR_W(ADDR_W)) uChecker (.*);

//--- basicOpPipe_tb.sv
module basicOpPipe_tb;

	import basicOpPkg::*;

	localparam int NUM_LANES = 4;
	localparam int ADDR_W = 8;
	localparam int TIMEOUT = 400;

	logic clk;
	logic rstN;
	logic opValid;
	logic opReady;
	basicOpCode opCode;
	basicOpWord opA;
	basicOpWord opB;
	basicOpWord opC;
	logic [ADDR_W-1:0] opDest;
	logic resValid;
	logic resReady;
	basicOpWord resData;
	logic resOverflow;
	logic [ADDR_W-1:0] resDest;
	logic memSel;
	logic testWrite;
	logic [ADDR_W-1:0] testAddr;
	logic [31:0] testData;
	logic [ADDR_W-1:0] readAddr;
	logic [31:0] readData;
	logic checkRead;
	logic randomReady;
	int errorCount;
	int checkCount;
	int pending;
	int tbErrors;
	int errBefore;
	int seedValue;
	logic [ADDR_W-1:0] usedDest [$];
	logic [ADDR_W-1:0] d;

	tbClock clockGen (.clk(clk));

	basicOpPipe #(.NUM_LANES(NUM_LANES), .ADDR_W(ADDR_W)) uut (.*);

	basicOpMonitor #(.ADDR_W(ADDR_W)) monitor (.*);

	// Random or steady back-pressure
	always @(negedge clk)
	begin
		resReady = randomReady ? ($urandom % 2 == 1) : 1'b1;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	function automatic basicOpWord pickLong();
		basicOpWord w;
		w.l = $urandom;
		case ($urandom % 8)
			0: w.l = MAX32;
			1: w.l = MIN32;
			2: w.l = MAX32 - 32'($urandom % 64);
			3: w.l = MIN32 + 32'($urandom % 64);
			4: w.w.lo = ($urandom % 2 == 1) ? MIN16 : MAX16;
			5: w.w.lo = 16'($urandom % 3) - 16'sd1;
			default: ;
		endcase
		return w;
	endfunction

	// Shift count of either sign, beyond 31 at times
	function automatic basicOpWord pickCount();
		basicOpWord w;
		w.l = $urandom;
		case ($urandom % 4)
			0: w.w.lo = ($urandom % 2 == 1) ? MIN16 : MAX16;
			default: w.w.lo = 16'(int'($urandom % 81) - 40);
		endcase
		return w;
	endfunction

	task automatic timeoutFail(input string what);
		$display("Timeout, %s", what);
		$display("test failed");
		$finish;
	endtask

	task automatic sendOp(input basicOpCode code, input basicOpWord a, input basicOpWord b,
		input basicOpWord c, input logic [ADDR_W-1:0] dest);
		int w;
		@(negedge clk);
		opCode = code;
		opA = a;
		opB = b;
		opC = c;
		opDest = dest;
		opValid = 1'b1;
		#1;
		w = 0;
		while (!opReady)
		begin
			@(negedge clk);
			#1;
			w++;
			if (w > TIMEOUT)
				timeoutFail("opReady stayed low");
		end
		@(posedge clk);
	endtask

	task automatic sendRandom(input int kind, input logic [ADDR_W-1:0] dest);
		basicOpCode code;
		case (kind)
			0: code = basicOpCode'(4'($urandom % 4));
			1: code = basicOpCode'(4'(4 + $urandom % 5));
			2: code = basicOpCode'(4'(9 + $urandom % 3));
			default: code = basicOpCode'(4'($urandom % 12));
		endcase
		if (code == opShr || code == opLShl || code == opLShr)
			sendOp(code, pickLong(), pickCount(), pickLong(), dest);
		else
			sendOp(code, pickLong(), pickLong(), pickLong(), dest);
	endtask

	task automatic drainAll();
		int w;
		@(negedge clk);
		opValid = 1'b0;
		w = 0;
		while (pending != 0)
		begin
			@(negedge clk);
			w++;
			if (w > TIMEOUT)
				timeoutFail("results did not drain");
		end
	endtask

	task automatic runBurst(input int count, input int kind);
		for (int i = 0; i < count; i++)
			sendRandom(kind, ADDR_W'($urandom));
		drainAll();
	endtask

	// MIN16 squared and long sums just past the limits
	task automatic sendCorners();
		basicOpWord m;
		basicOpWord c;
		basicOpWord top;
		basicOpWord bottom;
		m.l = 32'hffff_8000;
		c.l = 32'h0000_1234;
		top.l = MAX32;
		bottom.l = MIN32;
		sendOp(opMult, m, m, c, ADDR_W'(1));
		sendOp(opLMult, m, m, c, ADDR_W'(2));
		sendOp(opLMac, m, m, c, ADDR_W'(3));
		sendOp(opLMsu, m, m, c, ADDR_W'(4));
		sendOp(opLAdd, top, top, c, ADDR_W'(5));
		sendOp(opLSub, bottom, top, c, ADDR_W'(6));
		drainAll();
	endtask

	task automatic readAll();
		foreach (usedDest[i])
		begin
			@(negedge clk);
			readAddr = usedDest[i];
			checkRead = 1'b1;
		end
		@(negedge clk);
		checkRead = 1'b0;
		@(negedge clk);
	endtask

	task automatic reportTest(input string name);
		$display("Test %s finished, %0d errors", name, errorCount + tbErrors - errBefore);
		errBefore = errorCount + tbErrors;
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		seedValue = int'($urandom(32'hdb31_33d1));
		rstN = 1'b0;
		opValid = 1'b0;
		opCode = opAdd;
		opA = '0;
		opB = '0;
		opC = '0;
		opDest = '0;
		resReady = 1'b1;
		memSel = 1'b0;
		testWrite = 1'b0;
		testAddr = '0;
		testData = '0;
		readAddr = '0;
		checkRead = 1'b0;
		randomReady = 1'b0;
		tbErrors = 0;
		errBefore = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Empty pipe after reset
		if (opReady !== 1'b1)
		begin
			$display("Error opReady expected %h actual %h", 1'b1, opReady);
			tbErrors++;
		end
		if (resValid !== 1'b0)
		begin
			$display("Error resValid expected %h actual %h", 1'b0, resValid);
			tbErrors++;
		end
		reportTest("reset state");

		runBurst(80, 0);
		reportTest("short arithmetic");
		runBurst(80, 1);
		sendCorners();
		reportTest("long arithmetic");
		runBurst(80, 2);
		reportTest("shifts and norm_s");

		randomReady = 1'b1;
		repeat (5) runBurst(30, 3);
		randomReady = 1'b0;
		reportTest("ordering under back-pressure");

		// Collector owns the memory
		for (int i = 0; i < 20; i++)
		begin
			d = ADDR_W'(i * 5);
			usedDest.push_back(d);
			sendRandom(3, d);
		end
		drainAll();
		readAll();
		// Test port owns the memory
		memSel = 1'b1;
		for (int i = 0; i < 6; i++)
		begin
			@(negedge clk);
			testWrite = 1'b1;
			testAddr = ADDR_W'(200 + i);
			testData = $urandom;
		end
		@(negedge clk);
		testWrite = 1'b0;
		for (int i = 0; i < 10; i++)
			sendRandom(3, usedDest[i]);
		drainAll();
		for (int i = 0; i < 6; i++)
			usedDest.push_back(ADDR_W'(200 + i));
		readAll();
		memSel = 1'b0;
		reportTest("scratch memory ownership");

		$display("Checks %0d, errors %0d", checkCount, errorCount + tbErrors);
		if (errorCount + tbErrors == 0 && checkCount > 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- basicOpPkg.sv
package basicOpPkg;

	//////////////////////////////////////////////////
	// Operation codes
	//////////////////////////////////////////////////

	// Twelve basic operators of the codec
	typedef enum logic [3:0]
	{
		opAdd,
		opSub,
		opMult,
		opShr,
		opLAdd,
		opLSub,
		opLMult,
		opLMac,
		opLMsu,
		opLShl,
		opLShr,
		opNormS
	} basicOpCode;

	//////////////////////////////////////////////////
	// Operand and result word
	//////////////////////////////////////////////////

	// Long view or two 16-bit halves
	// 16-bit ops use w.lo only, w.hi carries the sign
	typedef union packed
	{
		logic signed [31:0] l;
		struct packed
		{
			logic signed [15:0] hi;
			logic signed [15:0] lo;
		} w;
	} basicOpWord;

	// Saturation limits
	localparam logic signed [15:0] MAX16 = 16'sh7fff;
	localparam logic signed [15:0] MIN16 = 16'sh8000;
	localparam logic signed [31:0] MAX32 = 32'sh7fff_ffff;
	localparam logic signed [31:0] MIN32 = 32'sh8000_0000;

endpackage

//--- opDispatcher.sv
module opDispatcher
#(
	parameter int NUM_LANES = 4,
	parameter int ADDR_W = 8
)
(
	input logic clk,
	input logic rstN,
	input logic opValid,
	output logic opReady,
	input basicOpPkg::basicOpCode opCode,
	input basicOpPkg::basicOpWord opA,
	input basicOpPkg::basicOpWord opB,
	input basicOpPkg::basicOpWord opC,
	input logic [ADDR_W-1:0] opDest,
	input logic [NUM_LANES-1:0] laneInReady,
	output logic [NUM_LANES-1:0] laneInValid,
	output basicOpPkg::basicOpCode laneOpCode,
	output basicOpPkg::basicOpWord laneA,
	output basicOpPkg::basicOpWord laneB,
	output basicOpPkg::basicOpWord laneC,
	output logic [ADDR_W-1:0] laneDest
);

	localparam int PTR_W = $clog2(NUM_LANES);

	logic [PTR_W-1:0] ptr;
	logic accept;

	// Stream is ready when the next lane in turn is
	assign opReady = laneInReady[ptr];
	assign accept = opValid && opReady;

	// Only the selected lane sees a valid
	always_comb
	begin
		laneInValid = '0;
		laneInValid[ptr] = opValid;
	end

	// Operation fields go to all lanes
	assign laneOpCode = opCode;
	assign laneA = opA;
	assign laneB = opB;
	assign laneC = opC;
	assign laneDest = opDest;

	// Round-robin pointer, moves on a handshake only
	always_ff @(posedge clk)
	begin
		if (!rstN)
			ptr <= '0;
		else if (accept)
		begin
			if (ptr == PTR_W'(NUM_LANES - 1))
				ptr <= '0;
			else
				ptr <= ptr + PTR_W'(1);
		end
	end

endmodule

//--- resultCollector.sv
module resultCollector
#(
	parameter int NUM_LANES = 4,
	parameter int ADDR_W = 8
)
(
	input logic clk,
	input logic rstN,
	input logic [NUM_LANES-1:0] laneOutValid,
	output logic [NUM_LANES-1:0] laneOutReady,
	input basicOpPkg::basicOpWord [NUM_LANES-1:0] laneResult,
	input logic [NUM_LANES-1:0] laneOverflow,
	input logic [NUM_LANES-1:0][ADDR_W-1:0] laneResDest,
	output logic resValid,
	input logic resReady,
	output basicOpPkg::basicOpWord resData,
	output logic resOverflow,
	output logic [ADDR_W-1:0] resDest,
	input logic memSel,
	output logic wrEn,
	output logic [ADDR_W-1:0] wrAddr,
	output logic [31:0] wrData
);

	localparam int PTR_W = $clog2(NUM_LANES);

	logic [PTR_W-1:0] ptr;
	logic transfer;

	//////////////////////////////////////////////////
	// Result stream
	//////////////////////////////////////////////////

	// Selected lane drives the stream
	assign resValid = laneOutValid[ptr];
	assign resData = laneResult[ptr];
	assign resOverflow = laneOverflow[ptr];
	assign resDest = laneResDest[ptr];
	assign transfer = resValid && resReady;

	always_comb
	begin
		laneOutReady = '0;
		laneOutReady[ptr] = resReady;
	end

	// Same walk as the dispatcher keeps issue order
	always_ff @(posedge clk)
	begin
		if (!rstN)
			ptr <= '0;
		else if (transfer)
		begin
			if (ptr == PTR_W'(NUM_LANES - 1))
				ptr <= '0;
			else
				ptr <= ptr + PTR_W'(1);
		end
	end

	//////////////////////////////////////////////////
	// Scratch write
	//////////////////////////////////////////////////

	// Test port owns the memory while memSel is high
	assign wrEn = transfer && !memSel;
	assign wrAddr = resDest;
	assign wrData = resData;

endmodule

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f basicOpPipe.f --top-module basicOpPipe_tb \
	-o basicOpPipe_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/basicOpPipe_sim > sim.log 2>&1 || echo "test failed" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

//--- scratchMem.sv
module scratchMem
#(
	parameter int ADDR_W = 8
)
(
	input logic clk,
	input logic wrEn,
	input logic [ADDR_W-1:0] wrAddr,
	input logic [31:0] wrData,
	input logic memSel,
	input logic testWrite,
	input logic [ADDR_W-1:0] testAddr,
	input logic [31:0] testData,
	input logic [ADDR_W-1:0] readAddr,
	output logic [31:0] readData
);

	logic [31:0] mem [2**ADDR_W];

	logic memWe;
	logic [ADDR_W-1:0] memAddr;
	logic [31:0] memData;

	// Write source, collector or test port
	assign memWe = memSel ? testWrite : wrEn;
	assign memAddr = memSel ? testAddr : wrAddr;
	assign memData = memSel ? testData : wrData;

	always_ff @(posedge clk)
	begin
		if (memWe)
			mem[memAddr] <= memData;
	end

	// Registered read, one cycle behind the address
	always_ff @(posedge clk)
	begin
		readData <= mem[readAddr];
	end

endmodule

//--- tbClock.sv
module tbClock
#(
	parameter int PERIOD = 4
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule
